// File: rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // Bit positions of the instruction fields
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    typedef enum logic [OPCODE_W-1:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ     = 3'b000; // Branch group
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_WORD    = 3'b010; // LW and SW

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

endpackage

// File: rtl/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int RAM_WORDS  = 64;   // Word index from address bits 7:2

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B   // LUI
    } alu_op_e;

endpackage

// File: rtl/register_bank.sv
module register_bank (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                write_enable,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] write_address,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       write_value,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] read_address1,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] read_address2,
    output logic [cpu_pipe_pkg::XLEN-1:0]       value1,
    output logic [cpu_pipe_pkg::XLEN-1:0]       value2
);

    logic [cpu_pipe_pkg::XLEN-1:0] regs [1:cpu_pipe_pkg::NUM_REGS-1];  // No storage for x0

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < cpu_pipe_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            regs[write_address] <= write_value;
        end
    end

    // Same-cycle write shows through, which covers distance-two dependencies
    function automatic logic [cpu_pipe_pkg::XLEN-1:0] read_port(
        input logic [cpu_pipe_pkg::REG_ADDR_W-1:0] address
    );
        if (address == '0) return '0;
        if (write_enable && address == write_address) return write_value;
        return regs[address];
    endfunction

    always_comb begin
        value1 = read_port(read_address1);
        value2 = read_port(read_address2);
    end

endmodule

// File: rtl/decode.sv
module decode (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                enable,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       rom_data,
    output logic [cpu_pipe_pkg::XLEN-1:0]       rom_address,
    input  logic                                branch_taken,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       branch_target,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] rb_read_address1,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] rb_read_address2,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       rb_value1,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       rb_value2,
    output logic                                de_valid,
    output logic [cpu_pipe_pkg::XLEN-1:0]       de_pc,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] de_rs1,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] de_rs2,
    output logic [cpu_pipe_pkg::XLEN-1:0]       de_value1,
    output logic [cpu_pipe_pkg::XLEN-1:0]       de_value2,
    output logic [cpu_pipe_pkg::XLEN-1:0]       de_imm,
    output cpu_pipe_pkg::alu_op_e               de_alu_op,
    output logic                                de_alu_src,
    output logic                                de_mem_read,
    output logic                                de_mem_write,
    output logic                                de_reg_write,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] de_rd,
    output logic                                de_branch,
    output logic                                de_branch_ne
);

    logic [cpu_pipe_pkg::XLEN-1:0] pc;
    cpu_isa_pkg::opcode_e          opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [cpu_pipe_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
    logic [cpu_pipe_pkg::XLEN-1:0] imm;
    cpu_pipe_pkg::alu_op_e         alu_op;
    logic                          alu_src, mem_read, mem_write, reg_write;
    logic                          branch, branch_ne;

    assign rom_address = pc;

    assign opcode = cpu_isa_pkg::opcode_e'(rom_data[cpu_isa_pkg::OPCODE_W-1:0]);
    assign funct3 = rom_data[cpu_isa_pkg::FUNCT3_LSB +: 3];
    assign funct7 = rom_data[cpu_isa_pkg::FUNCT7_LSB +: 7];
    assign rb_read_address1 = rom_data[cpu_isa_pkg::RS1_LSB +: cpu_pipe_pkg::REG_ADDR_W];
    assign rb_read_address2 = rom_data[cpu_isa_pkg::RS2_LSB +: cpu_pipe_pkg::REG_ADDR_W];

    // Sign-extended immediates per format
    assign imm_i = {{20{rom_data[31]}}, rom_data[31:20]};
    assign imm_s = {{20{rom_data[31]}}, rom_data[31:25], rom_data[11:7]};
    assign imm_b = {{19{rom_data[31]}}, rom_data[31], rom_data[7], rom_data[30:25],
                    rom_data[11:8], 1'b0};
    assign imm_u = {rom_data[31:12], 12'b0};

    always_comb begin
        imm       = imm_i;
        alu_op    = cpu_pipe_pkg::ALU_ADD;
        alu_src   = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;   // Unknown words fall through as no-ops
        case (opcode)
            cpu_isa_pkg::OP_REG: begin
                alu_src   = 1'b0;
                reg_write = 1'b1;
                case (funct3)
                    cpu_isa_pkg::F3_ADD_SUB: alu_op = (funct7 == cpu_isa_pkg::FUNCT7_SUB) ?
                                                      cpu_pipe_pkg::ALU_SUB :
                                                      cpu_pipe_pkg::ALU_ADD;
                    cpu_isa_pkg::F3_SLT: alu_op = cpu_pipe_pkg::ALU_SLT;
                    cpu_isa_pkg::F3_XOR: alu_op = cpu_pipe_pkg::ALU_XOR;
                    cpu_isa_pkg::F3_OR:  alu_op = cpu_pipe_pkg::ALU_OR;
                    cpu_isa_pkg::F3_AND: alu_op = cpu_pipe_pkg::ALU_AND;
                    default:             reg_write = 1'b0;   // Shifts, SLTU
                endcase
                // Only SUB may carry a nonzero funct7
                if (funct7 != cpu_isa_pkg::FUNCT7_BASE &&
                    !(funct7 == cpu_isa_pkg::FUNCT7_SUB && funct3 == cpu_isa_pkg::F3_ADD_SUB)) begin
                    reg_write = 1'b0;
                end
            end
            cpu_isa_pkg::OP_IMM: begin
                reg_write = (funct3 == cpu_isa_pkg::F3_ADD_SUB);   // ADDI only
            end
            cpu_isa_pkg::OP_LUI: begin
                imm       = imm_u;
                alu_op    = cpu_pipe_pkg::ALU_PASS_B;
                reg_write = 1'b1;
            end
            cpu_isa_pkg::OP_LOAD: begin
                mem_read  = (funct3 == cpu_isa_pkg::F3_WORD);
                reg_write = (funct3 == cpu_isa_pkg::F3_WORD);
            end
            cpu_isa_pkg::OP_STORE: begin
                imm       = imm_s;
                mem_write = (funct3 == cpu_isa_pkg::F3_WORD);
            end
            cpu_isa_pkg::OP_BRANCH: begin
                imm       = imm_b;
                alu_src   = 1'b0;
                branch    = (funct3 == cpu_isa_pkg::F3_BEQ) || (funct3 == cpu_isa_pkg::F3_BNE);
                branch_ne = (funct3 == cpu_isa_pkg::F3_BNE);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= cpu_pipe_pkg::RESET_PC;
            de_valid     <= 1'b0;
            de_mem_read  <= 1'b0;
            de_mem_write <= 1'b0;
            de_reg_write <= 1'b0;
            de_branch    <= 1'b0;
        end else if (enable) begin
            pc           <= branch_taken ? branch_target : pc + 32'd4;
            de_valid     <= !branch_taken;   // Bubble in the slot behind a taken branch
            de_mem_read  <= mem_read;
            de_mem_write <= mem_write;
            de_reg_write <= reg_write;
            de_branch    <= branch;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            de_pc        <= pc;
            de_rs1       <= rb_read_address1;
            de_rs2       <= rb_read_address2;
            de_value1    <= rb_value1;
            de_value2    <= rb_value2;
            de_imm       <= imm;
            de_alu_op    <= alu_op;
            de_alu_src   <= alu_src;
            de_rd        <= rom_data[cpu_isa_pkg::RD_LSB +: cpu_pipe_pkg::REG_ADDR_W];
            de_branch_ne <= branch_ne;
        end
    end

endmodule

// File: rtl/execute.sv
module execute (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                enable,
    input  logic                                de_valid,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       de_pc,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] de_rs1,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] de_rs2,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       de_value1,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       de_value2,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       de_imm,
    input  cpu_pipe_pkg::alu_op_e               de_alu_op,
    input  logic                                de_alu_src,
    input  logic                                de_mem_read,
    input  logic                                de_mem_write,
    input  logic                                de_reg_write,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] de_rd,
    input  logic                                de_branch,
    input  logic                                de_branch_ne,
    input  logic                                wb_valid,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       wb_value,
    output logic                                branch_taken,
    output logic [cpu_pipe_pkg::XLEN-1:0]       branch_target,
    output logic                                ex_valid,
    output logic [cpu_pipe_pkg::XLEN-1:0]       ex_result,
    output logic [cpu_pipe_pkg::XLEN-1:0]       ex_store_value,
    output logic                                ex_mem_read,
    output logic                                ex_mem_write,
    output logic                                ex_reg_write,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] ex_rd
);

    logic [cpu_pipe_pkg::XLEN-1:0] src1, src2;
    logic [cpu_pipe_pkg::XLEN-1:0] op_b;
    logic [cpu_pipe_pkg::XLEN-1:0] alu_out;

    // Producer one ahead sits in the result stage
    assign src1 = (wb_valid && wb_rd == de_rs1) ? wb_value : de_value1;
    assign src2 = (wb_valid && wb_rd == de_rs2) ? wb_value : de_value2;
    assign op_b = de_alu_src ? de_imm : src2;

    always_comb begin
        case (de_alu_op)
            cpu_pipe_pkg::ALU_ADD:    alu_out = src1 + op_b;
            cpu_pipe_pkg::ALU_SUB:    alu_out = src1 - op_b;
            cpu_pipe_pkg::ALU_AND:    alu_out = src1 & op_b;
            cpu_pipe_pkg::ALU_OR:     alu_out = src1 | op_b;
            cpu_pipe_pkg::ALU_XOR:    alu_out = src1 ^ op_b;
            cpu_pipe_pkg::ALU_SLT:    alu_out = {{(cpu_pipe_pkg::XLEN-1){1'b0}},
                                                 ($signed(src1) < $signed(op_b))};
            cpu_pipe_pkg::ALU_PASS_B: alu_out = op_b;
            default:                  alu_out = '0;
        endcase
    end

    // Only raised when decode will act on it this edge
    assign branch_taken  = enable && de_valid && de_branch && ((src1 == src2) != de_branch_ne);
    assign branch_target = de_pc + de_imm;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (enable) begin
            ex_valid     <= de_valid;
            ex_mem_read  <= de_mem_read;
            ex_mem_write <= de_mem_write;
            ex_reg_write <= de_reg_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            ex_result      <= alu_out;   // Also the load/store address
            ex_store_value <= src2;
            ex_rd          <= de_rd;
        end
    end

endmodule

// File: rtl/result.sv
module result (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                enable,
    input  logic                                ex_valid,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       ex_result,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       ex_store_value,
    input  logic                                ex_mem_read,
    input  logic                                ex_mem_write,
    input  logic                                ex_reg_write,
    input  logic [cpu_pipe_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                                wb_valid,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [cpu_pipe_pkg::XLEN-1:0]       wb_value
);

    logic [cpu_pipe_pkg::XLEN-1:0]               ram [cpu_pipe_pkg::RAM_WORDS];
    logic [$clog2(cpu_pipe_pkg::RAM_WORDS)-1:0] word_address;
    logic [cpu_pipe_pkg::XLEN-1:0]               load_data;

    assign word_address = ex_result[2 +: $bits(word_address)];   // Drop the byte offset
    assign load_data    = ram[word_address];

    // Contents survive reset, but nothing is written while it is held
    always_ff @(posedge clock) begin
        if (enable && rst_n && ex_valid && ex_mem_write) begin
            ram[word_address] <= ex_store_value;
        end
    end

    assign wb_valid = enable && ex_valid && ex_reg_write && (ex_rd != '0);
    assign wb_rd    = ex_rd;
    assign wb_value = ex_mem_read ? load_data : ex_result;   // Load data forwards too

endmodule

// File: rtl/cpu.sv
module cpu (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                enable,
    input  logic [cpu_pipe_pkg::XLEN-1:0]       rom_data,
    output logic [cpu_pipe_pkg::XLEN-1:0]       rom_address,
    output logic                                wb_valid,
    output logic [cpu_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [cpu_pipe_pkg::XLEN-1:0]       wb_value
);

    // Register bank read side
    logic [cpu_pipe_pkg::REG_ADDR_W-1:0] rb_read_address1, rb_read_address2;
    logic [cpu_pipe_pkg::XLEN-1:0]       rb_value1, rb_value2;

    // Decode to execute
    logic                                de_valid;
    logic [cpu_pipe_pkg::XLEN-1:0]       de_pc, de_value1, de_value2, de_imm;
    logic [cpu_pipe_pkg::REG_ADDR_W-1:0] de_rs1, de_rs2, de_rd;
    cpu_pipe_pkg::alu_op_e               de_alu_op;
    logic                                de_alu_src, de_mem_read, de_mem_write, de_reg_write;
    logic                                de_branch, de_branch_ne;

    logic                                branch_taken;    // Redirect back to fetch
    logic [cpu_pipe_pkg::XLEN-1:0]       branch_target;

    // Execute to result
    logic                                ex_valid, ex_mem_read, ex_mem_write, ex_reg_write;
    logic [cpu_pipe_pkg::XLEN-1:0]       ex_result, ex_store_value;
    logic [cpu_pipe_pkg::REG_ADDR_W-1:0] ex_rd;

    decode u_decode (
        .clock, .rst_n, .enable, .rom_data, .rom_address,
        .branch_taken, .branch_target,
        .rb_read_address1, .rb_read_address2, .rb_value1, .rb_value2,
        .de_valid, .de_pc, .de_rs1, .de_rs2, .de_value1, .de_value2, .de_imm,
        .de_alu_op, .de_alu_src, .de_mem_read, .de_mem_write, .de_reg_write,
        .de_rd, .de_branch, .de_branch_ne
    );

    execute u_execute (
        .clock, .rst_n, .enable,
        .de_valid, .de_pc, .de_rs1, .de_rs2, .de_value1, .de_value2, .de_imm,
        .de_alu_op, .de_alu_src, .de_mem_read, .de_mem_write, .de_reg_write,
        .de_rd, .de_branch, .de_branch_ne,
        .wb_valid, .wb_rd, .wb_value,
        .branch_taken, .branch_target,
        .ex_valid, .ex_result, .ex_store_value, .ex_mem_read, .ex_mem_write,
        .ex_reg_write, .ex_rd
    );

    result u_result (
        .clock, .rst_n, .enable,
        .ex_valid, .ex_result, .ex_store_value, .ex_mem_read, .ex_mem_write,
        .ex_reg_write, .ex_rd,
        .wb_valid, .wb_rd, .wb_value
    );

    register_bank u_register_bank (
        .clock,
        .rst_n,
        .write_enable  (wb_valid),   // Already gated by enable
        .write_address (wb_rd),
        .write_value   (wb_value),
        .read_address1 (rb_read_address1),
        .read_address2 (rb_read_address2),
        .value1        (rb_value1),
        .value2        (rb_value2)
    );

endmodule

// File: testbench/cpu_sva.sv
module cpu_sva (
    input logic                                clock,
    input logic                                rst_n,
    input logic                                enable,
    input logic                                wb_valid,
    input logic [cpu_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    input logic                                branch_taken,
    input logic                                de_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    wb_quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !wb_valid)
        else $error("write port active during reset");

    wb_rd_nonzero: assert property (@(posedge clock) disable iff (!rst_n)
        wb_valid |-> wb_rd != '0)
        else $error("write port targets x0");

    wb_quiet_when_held: assert property (@(posedge clock) disable iff (!rst_n)
        !enable |-> !wb_valid)
        else $error("write port active while enable is low");

    // Taken branch already includes enable, so the next edge is the enabled one
    squash_after_branch: assert property (@(posedge clock) disable iff (!rst_n)
        branch_taken |=> !de_valid)
        else $error("slot behind a taken branch was not squashed");

endmodule

// File: testbench/cpu_checker.sv
module cpu_checker #(
    parameter int PROG_LEN = 40
) (
    input logic                                clock,
    input logic                                rst_n,
    input logic                                enable,
    input logic [cpu_pipe_pkg::XLEN-1:0]       rom_address,
    input logic                                wb_valid,
    input logic [cpu_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    input logic [cpu_pipe_pkg::XLEN-1:0]       wb_value
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUDGET = 4 * PROG_LEN + 50;   // Cycles allowed per test

    logic [31:0] model_regs [32];
    logic [31:0] model_ram [cpu_pipe_pkg::RAM_WORDS];   // Kept across tests like the DUT RAM
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_value [$];
    string       test_name;
    bit          busy = 0;
    bit          done = 0;
    int          quiet, cycles, seen, test_errors;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_ok = 0;

    // Runs the program in order and queues every write to a nonzero register
    task automatic start_test(input string name, input logic [31:0] words [64]);
        logic [31:0] pc, w, a, b, value, next_pc, addr;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        bit          writes;
        test_name = name;
        exp_rd.delete();
        exp_value.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        pc = cpu_pipe_pkg::RESET_PC;
        while (pc < 32'(4 * PROG_LEN)) begin
            w       = words[pc[7:2]];
            rd      = w[11:7];
            f3      = w[14:12];
            f7      = w[31:25];
            a       = model_regs[w[19:15]];
            b       = model_regs[w[24:20]];
            next_pc = pc + 32'd4;
            writes  = 0;
            value   = '0;
            case (w[6:0])
                cpu_isa_pkg::OP_REG: begin
                    writes = 1;
                    if (f3 == cpu_isa_pkg::F3_ADD_SUB && f7 == cpu_isa_pkg::FUNCT7_SUB) value = a - b;
                    else if (f7 != 7'd0) writes = 0;
                    else if (f3 == cpu_isa_pkg::F3_ADD_SUB) value = a + b;
                    else if (f3 == cpu_isa_pkg::F3_AND) value = a & b;
                    else if (f3 == cpu_isa_pkg::F3_OR)  value = a | b;
                    else if (f3 == cpu_isa_pkg::F3_XOR) value = a ^ b;
                    else if (f3 == cpu_isa_pkg::F3_SLT) value = {31'd0, $signed(a) < $signed(b)};
                    else writes = 0;
                end
                cpu_isa_pkg::OP_IMM: begin
                    writes = (f3 == cpu_isa_pkg::F3_ADD_SUB);
                    value  = a + {{20{w[31]}}, w[31:20]};
                end
                cpu_isa_pkg::OP_LUI: begin
                    writes = 1;
                    value  = {w[31:12], 12'd0};
                end
                cpu_isa_pkg::OP_LOAD: begin
                    addr   = a + {{20{w[31]}}, w[31:20]};
                    writes = (f3 == cpu_isa_pkg::F3_WORD);
                    value  = model_ram[addr[7:2]];
                end
                cpu_isa_pkg::OP_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    if (f3 == cpu_isa_pkg::F3_WORD) model_ram[addr[7:2]] = b;
                end
                cpu_isa_pkg::OP_BRANCH: begin
                    if ((f3 == cpu_isa_pkg::F3_BEQ && a == b) ||
                        (f3 == cpu_isa_pkg::F3_BNE && a != b)) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default: ;   // No-op
            endcase
            if (writes && rd != 5'd0) begin
                model_regs[rd] = value;
                exp_rd.push_back(rd);
                exp_value.push_back(value);
            end
            pc = next_pc;
        end
        quiet       = 0;
        cycles      = 0;
        seen        = 0;
        test_errors = 0;
        done        = 0;
        busy        = 1;
    endtask

    function automatic void finish_test();
        busy = 0;
        done = 1;
        tests_run++;
        if (test_errors == 0) begin
            tests_ok++;
            $display("%s: ok, %0d writes", test_name, seen);
        end else begin
            $display("%s: FAILED with %0d errors", test_name, test_errors);
        end
    endfunction

    function automatic void report_totals();
        $display("%0d tests, %0d ok, %0d errors", tests_run, tests_ok, error_count);
    endfunction

    always @(posedge clock) begin
        if (busy && rst_n) begin
            cycles++;
            // First cycle out of reset still fetches from the reset PC
            if (cycles == 1 && rom_address != cpu_pipe_pkg::RESET_PC) begin
                $display("[ERROR] %s: fetch address after reset expected %08h, actual %08h",
                         test_name, cpu_pipe_pkg::RESET_PC, rom_address);
                test_errors++;
                error_count++;
            end
            if (wb_valid && !enable) begin
                $display("%s: write seen in a cycle with enable low", test_name);
                test_errors++;
                error_count++;
            end
            if (wb_valid) begin
                quiet = 0;
                if (exp_rd.size() == 0) begin
                    $display("%s: extra write to x%0d after the expected sequence",
                             test_name, wb_rd);
                    test_errors++;
                    error_count++;
                end else begin
                    if (wb_rd != exp_rd[0] || wb_value != exp_value[0]) begin
                        $display("[ERROR] %s: write %0d expected x%0d=%08h, actual x%0d=%08h",
                                 test_name, seen, exp_rd[0], exp_value[0], wb_rd, wb_value);
                        test_errors++;
                        error_count++;
                    end
                    void'(exp_rd.pop_front());
                    void'(exp_value.pop_front());
                    seen++;
                end
            end else if (exp_rd.size() == 0) begin
                quiet++;
            end
            if (exp_rd.size() == 0 && quiet >= 8) begin
                finish_test();
            end else if (cycles > BUDGET) begin
                $display("%s: %0d expected writes never appeared", test_name, exp_rd.size());
                test_errors++;
                error_count++;
                finish_test();
            end
        end
    end

endmodule

// File: testbench/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          PROG_LEN    = 40;
    localparam int          NUM_TESTS   = 6;
    localparam int          WATCHDOG_NS = NUM_TESTS * (16 + 4 * PROG_LEN + 50) * 4;
    localparam logic [31:0] NOP         = 32'h0000_0013;   // ADDI x0, x0, 0

    logic        clock = 0;
    logic        rst_n;
    logic        enable;
    logic [31:0] rom_data;
    logic [31:0] rom_address;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;

    logic [31:0] prog [64];
    bit          stall_mode = 0;
    int          hold_count = 0;
    string       names [NUM_TESTS] = '{"alu_reg", "immediate", "dependency",
                                       "load_store", "branch", "enable_stall"};

    always #2 clock = ~clock;

    cpu u_dut (.clock, .rst_n, .enable, .rom_data, .rom_address, .wb_valid, .wb_rd, .wb_value);

    cpu_checker #(.PROG_LEN(PROG_LEN)) u_checker (
        .clock, .rst_n, .enable, .rom_address, .wb_valid, .wb_rd, .wb_value
    );

    bind cpu cpu_sva u_sva (.*);

    // Combinational ROM, no-ops past the program
    assign rom_data = (rom_address < 32'(4 * PROG_LEN)) ? prog[rom_address[7:2]] : NOP;

    // Enable toggles in random stretches in the stall test
    always @(posedge clock) begin
        if (!stall_mode) begin
            enable <= 1'b1;
        end else if (hold_count > 0) begin
            hold_count <= hold_count - 1;
        end else begin
            enable     <= ~enable;
            hold_count <= $urandom_range(5, 0);
        end
    end

    function automatic logic [31:0] r_type_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_isa_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type_word(logic [6:0] op, logic [11:0] imm,
                                                logic [4:0] rs1, logic [4:0] rd);
        return {imm, rs1, cpu_isa_pkg::F3_ADD_SUB, rd, op};
    endfunction

    function automatic logic [31:0] store_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, cpu_isa_pkg::F3_WORD, imm[4:0], cpu_isa_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] load_word(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
        return {imm, rs1, cpu_isa_pkg::F3_WORD, rd, cpu_isa_pkg::OP_LOAD};
    endfunction

    function automatic logic [31:0] branch_word(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                                logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_isa_pkg::OP_BRANCH};
    endfunction

    // 0 R-type, 1 ADDI, 2 LUI, 3 load, 4 store, 5 branch
    function automatic int pick_class(int test);
        int r;
        r = $urandom_range(9, 0);
        case (test)
            0:       return (r < 8) ? 0 : 1;
            1:       return (r < 4) ? 1 : (r < 7) ? 2 : 0;
            2:       return (r < 6) ? 0 : 1;
            3:       return (r < 3) ? 4 : (r < 6) ? 3 : 0;
            default: return (r < 3) ? 5 : (r < 6) ? 0 : (r < 8) ? 1 : 3;
        endcase
    endfunction

    task automatic build_program(input int test);
        logic [2:0]  f3_pick [5] = '{cpu_isa_pkg::F3_ADD_SUB, cpu_isa_pkg::F3_SLT,
                                     cpu_isa_pkg::F3_XOR, cpu_isa_pkg::F3_OR, cpu_isa_pkg::F3_AND};
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] mem_off;
        int          cls, reg_max, target;
        reg_max = (test == 2) ? 3 : 7;   // Few registers keep dependencies close
        for (int i = 0; i < 64; i++) begin
            prog[i] = NOP;
        end
        for (int r = 1; r <= 6; r++) begin
            if (r % 2 == 1) prog[r-1] = i_type_word(cpu_isa_pkg::OP_IMM,
                                                     12'($urandom_range(4095, 0)), 5'd0, 5'(r));
            else prog[r-1] = {20'($urandom), 5'(r), cpu_isa_pkg::OP_LUI};
        end
        for (int k = 0; k < 4; k++) begin
            prog[6+k] = store_word(12'(4 * k), 5'(k + 1), 5'd0);   // Every RAM word a load can hit
        end
        for (int i = 10; i < PROG_LEN; i++) begin
            cls     = pick_class(test);
            rd      = 5'($urandom_range(reg_max, 0));
            rs1     = 5'($urandom_range(reg_max, 0));
            rs2     = 5'($urandom_range(reg_max, 0));
            mem_off = 12'(4 * $urandom_range(3, 0));
            if (cls == 5 && i == PROG_LEN - 1) cls = 0;
            case (cls)
                0: begin
                    f3 = f3_pick[$urandom_range(4, 0)];
                    f7 = (f3 == cpu_isa_pkg::F3_ADD_SUB && $urandom_range(1, 0) == 1) ?
                         cpu_isa_pkg::FUNCT7_SUB : 7'd0;
                    prog[i] = r_type_word(f7, rs2, rs1, f3, rd);
                end
                1: prog[i] = i_type_word(cpu_isa_pkg::OP_IMM, 12'($urandom), rs1, rd);
                2: prog[i] = {20'($urandom), rd, cpu_isa_pkg::OP_LUI};
                3: prog[i] = load_word(mem_off, 5'd0, rd);
                4: prog[i] = store_word(mem_off, rs2, 5'd0);
                default: begin
                    target  = $urandom_range(PROG_LEN - 1, i + 1);   // Forward only
                    f3      = ($urandom_range(1, 0) == 1) ? cpu_isa_pkg::F3_BNE : cpu_isa_pkg::F3_BEQ;
                    prog[i] = branch_word(13'(4 * (target - i)), rs2, rs1, f3);
                end
            endcase
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired before all tests finished");
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h5d33330c));
        rst_n  = 1'b0;
        enable = 1'b0;
        for (int i = 0; i < 64; i++) begin
            prog[i] = NOP;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clock);
            rst_n      <= 1'b0;
            stall_mode <= 1'b0;
            if (t != 5) build_program(t);   // Stall test reruns the branch program
            repeat (16) @(posedge clock);
            u_checker.start_test(names[t], prog);
            rst_n      <= 1'b1;
            stall_mode <= (t == 5);
            wait (u_checker.done);
        end
        u_checker.report_totals();
        if (u_checker.error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: cpu.f
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/register_bank.sv
rtl/decode.sv
rtl/execute.sv
rtl/result.sv
rtl/cpu.sv
testbench/cpu_sva.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcpu_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
